// File: hw/cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_i,
    input  logic               we_i,
    input  lsu_pkg::lsu_addr_t addr_i,
    input  lsu_pkg::size_t     size_i,
    input  logic               sign_i,
    input  logic [31:0]        wdata_i,
    output logic               ack_o,
    input  logic [3:0]         strobe_i,
    input  logic [31:0]        store_word_i,
    output logic [31:0]        load_word_o,
    cache_ram_if.ctrl          ram [lsu_pkg::WAY_CNT],
    output logic               bus_valid_o,
    output logic               bus_write_o,
    output logic [31:0]        bus_addr_o,
    input  logic               bus_ready_i,
    output logic               bus_wvalid_o,
    output logic               bus_wlast_o,
    output logic [31:0]        bus_wdata_o,
    input  logic               bus_data_ok_i,
    input  logic               bus_data_last_i,
    input  logic [31:0]        bus_rdata_i
);

    localparam logic [lsu_pkg::BEAT_W-1:0] LAST_BEAT = lsu_pkg::BEAT_W'(lsu_pkg::LINE_WORDS - 1);

    lsu_pkg::ctrl_state_t state, state_nx;

    // latched request
    lsu_pkg::lsu_addr_t addr_q;
    logic               we_q;
    logic [3:0]         strobe_q;
    logic [31:0]        store_q;

    // per-way read results
    logic [31:0]                   way_rdata [lsu_pkg::WAY_CNT];
    lsu_pkg::tag_t                 way_rtag [lsu_pkg::WAY_CNT];
    logic [lsu_pkg::WAY_CNT-1:0]   way_busy;
    logic [lsu_pkg::WAY_CNT-1:0]   hit;
    logic [lsu_pkg::WAY_W-1:0]     hit_way;

    // miss handling
    logic [lsu_pkg::LFSR_W-1:0]    lfsr;
    logic [lsu_pkg::WAY_W-1:0]     victim, victim_q;
    lsu_pkg::tag_t                 victim_tag_q;
    logic [lsu_pkg::BEAT_W-1:0]    wb_cnt, rf_cnt;
    logic                          fill_done;

    // shared ram port, enables go to one way only
    logic [lsu_pkg::SET_W-1:0]     rd_set;
    logic [lsu_pkg::BEAT_W-1:0]    rd_word;
    logic [lsu_pkg::WAY_W-1:0]     wr_way;
    logic [lsu_pkg::BEAT_W-1:0]    wr_word;
    logic [3:0]                    wr_be;
    logic                          wr_tag_en;
    logic [31:0]                   wr_data;
    lsu_pkg::tag_t                 wr_tag;
    lsu_pkg::lsu_addr_t            bus_addr;

    for (genvar w = 0; w < lsu_pkg::WAY_CNT; w++) begin : g_way
        localparam logic [lsu_pkg::WAY_W-1:0] WAY_ID = lsu_pkg::WAY_W'(w);

        assign ram[w].r_set   = rd_set;
        assign ram[w].r_word  = rd_word;
        assign ram[w].w_set   = addr_q.f.set_idx;
        assign ram[w].w_word  = wr_word;
        assign ram[w].w_data  = wr_data;
        assign ram[w].w_tag   = wr_tag;
        assign ram[w].data_we = (wr_way == WAY_ID) ? wr_be : 4'b0000;
        assign ram[w].tag_we  = (wr_way == WAY_ID) && wr_tag_en;

        assign way_rdata[w] = ram[w].r_data;
        assign way_rtag[w]  = ram[w].r_tag;
        assign way_busy[w]  = ram[w].init_busy;
        assign hit[w]       = ram[w].r_tag.valid && (ram[w].r_tag.ppn == addr_q.f.ppn);
    end

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < lsu_pkg::WAY_CNT; i++) begin
            if (hit[i]) begin
                hit_way = i[lsu_pkg::WAY_W-1:0];
            end
        end
    end

    assign victim = lfsr[lsu_pkg::WAY_W-1:0];

    always_comb begin
        state_nx = state;
        case (state)
            lsu_pkg::S_IDLE: begin
                if (req_i && !(|way_busy)) begin
                    state_nx = lsu_pkg::S_LOOKUP;
                end
            end
            lsu_pkg::S_LOOKUP: begin
                if (|hit) begin
                    state_nx = lsu_pkg::S_DONE;
                end else if (way_rtag[victim].valid && way_rtag[victim].dirty) begin
                    state_nx = lsu_pkg::S_WADR;
                end else begin
                    state_nx = lsu_pkg::S_RADR;
                end
            end
            lsu_pkg::S_WADR: begin
                if (bus_ready_i) begin
                    state_nx = lsu_pkg::S_WDAT;
                end
            end
            lsu_pkg::S_WDAT: begin
                if (bus_data_ok_i && wb_cnt == LAST_BEAT) begin
                    state_nx = lsu_pkg::S_RADR;
                end
            end
            lsu_pkg::S_RADR: begin
                if (bus_ready_i) begin
                    state_nx = lsu_pkg::S_RDAT;
                end
            end
            lsu_pkg::S_RDAT: begin
                // one spare cycle so the lookup reads the new line
                if (fill_done) begin
                    state_nx = lsu_pkg::S_LOOKUP;
                end
            end
            lsu_pkg::S_DONE: begin
                if (!req_i) begin
                    state_nx = lsu_pkg::S_IDLE;
                end
            end
            default: state_nx = lsu_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= lsu_pkg::S_IDLE;
            wb_cnt    <= '0;
            rf_cnt    <= '0;
            fill_done <= 1'b0;
            lfsr      <= lsu_pkg::LFSR_SEED;
        end else begin
            state <= state_nx;
            // both counters wrap back to 0 after four beats
            if (state == lsu_pkg::S_WDAT && bus_data_ok_i) begin
                wb_cnt <= wb_cnt + 1'b1;
            end
            if (state == lsu_pkg::S_RDAT && !fill_done && bus_data_ok_i) begin
                rf_cnt <= rf_cnt + 1'b1;
            end
            if (fill_done) begin
                fill_done <= 1'b0;
            end else if (state == lsu_pkg::S_RDAT && bus_data_ok_i && bus_data_last_i) begin
                fill_done <= 1'b1;
                // x^8 + x^6 + x^5 + x^4 + 1
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == lsu_pkg::S_IDLE) begin
            addr_q   <= addr_i;
            we_q     <= we_i;
            strobe_q <= strobe_i;
            store_q  <= store_word_i;
        end
        if (state == lsu_pkg::S_LOOKUP) begin
            load_word_o <= way_rdata[hit_way];
            if (!(|hit)) begin
                victim_q     <= victim;
                victim_tag_q <= way_rtag[victim];
            end
        end
    end

    // read address, line readout walks the words ahead of the bus
    always_comb begin
        rd_set  = addr_q.f.set_idx;
        rd_word = addr_q.f.word_off;
        case (state)
            lsu_pkg::S_IDLE: begin
                rd_set  = addr_i.f.set_idx;
                rd_word = addr_i.f.word_off;
            end
            lsu_pkg::S_WADR: rd_word = wb_cnt;
            lsu_pkg::S_WDAT: rd_word = bus_data_ok_i ? wb_cnt + 1'b1 : wb_cnt;
            default: ;
        endcase
    end

    // store hit or refill beat
    always_comb begin
        wr_way       = hit_way;
        wr_word      = addr_q.f.word_off;
        wr_be        = 4'b0000;
        wr_tag_en    = 1'b0;
        wr_data      = store_q;
        wr_tag.valid = 1'b1;
        wr_tag.dirty = 1'b1;
        wr_tag.ppn   = addr_q.f.ppn;
        if (state == lsu_pkg::S_LOOKUP && (|hit) && we_q) begin
            wr_be     = strobe_q;
            wr_tag_en = 1'b1;
        end else if (state == lsu_pkg::S_RDAT && !fill_done) begin
            wr_way       = victim_q;
            wr_word      = rf_cnt;
            wr_data      = bus_rdata_i;
            wr_be        = {4{bus_data_ok_i}};
            wr_tag_en    = bus_data_ok_i && bus_data_last_i;
            wr_tag.dirty = 1'b0;
        end
    end

    // line-aligned burst address, victim ppn for a writeback
    always_comb begin
        bus_addr            = addr_q;
        bus_addr.f.word_off = '0;
        bus_addr.f.byte_off = '0;
        if (state == lsu_pkg::S_WADR) begin
            bus_addr.f.ppn = victim_tag_q.ppn;
        end
    end

    assign bus_valid_o  = (state == lsu_pkg::S_WADR) || (state == lsu_pkg::S_RADR);
    assign bus_write_o  = (state == lsu_pkg::S_WADR);
    assign bus_addr_o   = bus_addr.raw;
    assign bus_wvalid_o = (state == lsu_pkg::S_WDAT);
    assign bus_wlast_o  = (state == lsu_pkg::S_WDAT) && (wb_cnt == LAST_BEAT);
    assign bus_wdata_o  = way_rdata[victim_q];
    assign ack_o        = (state == lsu_pkg::S_DONE);

    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bus_valid_o && !bus_ready_i |=>
            bus_valid_o && $stable(bus_addr_o) && $stable(bus_write_o));

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        state == lsu_pkg::S_IDLE && !req_i |=> !ack_o);

    // cpu keeps the request steady until it sees ack
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {lsu_pkg::S_LOOKUP, lsu_pkg::S_WADR, lsu_pkg::S_WDAT,
                      lsu_pkg::S_RADR, lsu_pkg::S_RDAT} |->
            req_i && $stable(addr_i) && $stable(we_i) && $stable(size_i) &&
            $stable(sign_i) && $stable(wdata_i));

endmodule

// File: hw/cache_ram_if.sv
`timescale 1ns/1ns

interface cache_ram_if;

    // read port, data comes back one cycle later
    logic [lsu_pkg::SET_W-1:0]  r_set;
    logic [lsu_pkg::BEAT_W-1:0] r_word;
    logic [31:0]                r_data;
    lsu_pkg::tag_t              r_tag;

    // write port
    logic [lsu_pkg::SET_W-1:0]  w_set;
    logic [lsu_pkg::BEAT_W-1:0] w_word;
    logic [3:0]                 data_we;
    logic                       tag_we;
    logic [31:0]                w_data;
    lsu_pkg::tag_t              w_tag;

    // high while the tag sweep after reset runs
    logic                       init_busy;

    modport ctrl (
        output r_set, r_word, w_set, w_word, data_we, tag_we, w_data, w_tag,
        input  r_data, r_tag, init_busy
    );

    modport ram (
        input  r_set, r_word, w_set, w_word, data_we, tag_we, w_data, w_tag,
        output r_data, r_tag, init_busy
    );

endinterface

// File: hw/cache_way_ram.sv
`timescale 1ns/1ns

module cache_way_ram (
    input  logic      clk,
    input  logic      rst_n,
    cache_ram_if.ram  ram
);

    lsu_pkg::tag_t tag_mem [lsu_pkg::SET_CNT];
    logic [31:0]   data_mem [lsu_pkg::SET_CNT * lsu_pkg::LINE_WORDS];

    // msb set once every set has been cleared
    logic [lsu_pkg::SET_W:0] sweep_cnt;
    logic                    sweeping;

    assign sweeping      = !sweep_cnt[lsu_pkg::SET_W];
    assign ram.init_busy = sweeping;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sweep_cnt <= '0;
        end else if (sweeping) begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end
    end

    // tag write, the sweep wins
    always_ff @(posedge clk) begin
        if (sweeping) begin
            tag_mem[sweep_cnt[lsu_pkg::SET_W-1:0]] <= '0;
        end else if (ram.tag_we) begin
            tag_mem[ram.w_set] <= ram.w_tag;
        end
    end

    // byte lanes
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (ram.data_we[b]) begin
                data_mem[{ram.w_set, ram.w_word}][8*b +: 8] <= ram.w_data[8*b +: 8];
            end
        end
    end

    // synchronous read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        ram.r_data <= data_mem[{ram.r_set, ram.r_word}];
        ram.r_tag  <= tag_mem[ram.r_set];
    end

    // controller must wait for the sweep to finish
    a_no_tag_we_in_sweep: assert property (@(posedge clk) disable iff (!rst_n)
        sweeping |-> !ram.tag_we);

endmodule

// File: hw/lsu_pkg.sv
package lsu_pkg;

    // cache geometry
    localparam int WAY_CNT    = 2;
    localparam int WAY_W      = 1;
    localparam int SET_CNT    = 256;
    localparam int SET_W      = 8;
    localparam int LINE_WORDS = 4;
    localparam int BEAT_W     = 2;
    localparam int PPN_W      = 20;

    // victim way generator
    localparam int LFSR_W = 8;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 8'hA5;

    // one address word, seen raw or split into cache fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [PPN_W-1:0]  ppn;
            logic [SET_W-1:0]  set_idx;
            logic [BEAT_W-1:0] word_off;
            logic [1:0]        byte_off;
        } f;
    } lsu_addr_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [PPN_W-1:0] ppn;
    } tag_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_t;

    // main controller states
    typedef enum logic [2:0] {
        S_IDLE   = 3'd0,
        S_LOOKUP = 3'd1,
        S_WADR   = 3'd2,
        S_WDAT   = 3'd3,
        S_RADR   = 3'd4,
        S_RDAT   = 3'd5,
        S_DONE   = 3'd6
    } ctrl_state_t;

endpackage

// File: hw/lsu_top.sv
`timescale 1ns/1ns

module lsu_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           req_i,
    input  logic           we_i,
    input  logic [31:0]    addr_i,
    input  lsu_pkg::size_t size_i,
    input  logic           sign_i,
    input  logic [31:0]    wdata_i,
    output logic           ack_o,
    output logic [31:0]    rdata_o,
    output logic           bus_valid_o,
    output logic           bus_write_o,
    output logic [31:0]    bus_addr_o,
    input  logic           bus_ready_i,
    output logic           bus_wvalid_o,
    output logic           bus_wlast_o,
    output logic [31:0]    bus_wdata_o,
    input  logic           bus_data_ok_i,
    input  logic           bus_data_last_i,
    input  logic [31:0]    bus_rdata_i
);

    lsu_pkg::lsu_addr_t addr_u;
    logic [3:0]         strobe;
    logic [31:0]        store_word;
    logic [31:0]        load_word;

    cache_ram_if ram_if [lsu_pkg::WAY_CNT] ();

    assign addr_u.raw = addr_i;

    // rdata follows the held cpu address and the latched hit word
    mem_align align_i (
        .addr_i       (addr_u),
        .size_i       (size_i),
        .sign_i       (sign_i),
        .store_data_i (wdata_i),
        .load_word_i  (load_word),
        .strobe_o     (strobe),
        .store_word_o (store_word),
        .load_data_o  (rdata_o)
    );

    cache_ctrl ctrl_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_i           (req_i),
        .we_i            (we_i),
        .addr_i          (addr_u),
        .size_i          (size_i),
        .sign_i          (sign_i),
        .wdata_i         (wdata_i),
        .ack_o           (ack_o),
        .strobe_i        (strobe),
        .store_word_i    (store_word),
        .load_word_o     (load_word),
        .ram             (ram_if),
        .bus_valid_o     (bus_valid_o),
        .bus_write_o     (bus_write_o),
        .bus_addr_o      (bus_addr_o),
        .bus_ready_i     (bus_ready_i),
        .bus_wvalid_o    (bus_wvalid_o),
        .bus_wlast_o     (bus_wlast_o),
        .bus_wdata_o     (bus_wdata_o),
        .bus_data_ok_i   (bus_data_ok_i),
        .bus_data_last_i (bus_data_last_i),
        .bus_rdata_i     (bus_rdata_i)
    );

    for (genvar w = 0; w < lsu_pkg::WAY_CNT; w++) begin : g_way
        cache_way_ram ram_i (
            .clk   (clk),
            .rst_n (rst_n),
            .ram   (ram_if[w])
        );
    end

endmodule

// File: hw/mem_align.sv
`timescale 1ns/1ns

module mem_align (
    input  lsu_pkg::lsu_addr_t addr_i,
    input  lsu_pkg::size_t     size_i,
    input  logic               sign_i,
    input  logic [31:0]        store_data_i,
    input  logic [31:0]        load_word_i,
    output logic [3:0]         strobe_o,
    output logic [31:0]        store_word_o,
    output logic [31:0]        load_data_o
);

    logic [1:0]  boff;
    logic [31:0] load_shift;

    assign boff = addr_i.f.byte_off;

    // byte strobe from size and offset
    always_comb begin
        case (size_i)
            lsu_pkg::SIZE_WORD: strobe_o = 4'b1111;
            lsu_pkg::SIZE_HALF: strobe_o = 4'b0011 << {boff[1], 1'b0};
            lsu_pkg::SIZE_BYTE: strobe_o = 4'b0001 << boff;
            default:            strobe_o = 4'b0000;
        endcase
    end

    // store data moves up to its byte lane
    assign store_word_o = store_data_i << {boff, 3'b000};

    // addressed bytes down to bit 0
    assign load_shift = load_word_i >> {boff, 3'b000};

    always_comb begin
        case (size_i)
            lsu_pkg::SIZE_BYTE: begin
                load_data_o = {{24{sign_i & load_shift[7]}}, load_shift[7:0]};
            end
            lsu_pkg::SIZE_HALF: begin
                load_data_o = {{16{sign_i & load_shift[15]}}, load_shift[15:0]};
            end
            default: begin
                load_data_o = load_word_i;
            end
        endcase
    end

    // misaligned accesses are not supported
    always_comb begin
        a_aligned: assert final (
            !(size_i == lsu_pkg::SIZE_HALF && boff[0]) &&
            !(size_i == lsu_pkg::SIZE_WORD && boff != 2'b00));
    end

endmodule

// File: list.f
hw/lsu_pkg.sv
hw/cache_ram_if.sv
hw/cache_way_ram.sv
hw/mem_align.sv
hw/cache_ctrl.sv
hw/lsu_top.sv
testbench/bus_mem_model.sv
testbench/tb_lsu.sv

// File: run.sh
#!/bin/sh
# build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_lsu -f list.f -o sim_lsu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_lsu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1

// File: testbench/bus_mem_model.sv
`timescale 1ns/1ns

module bus_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid_i,
    input  logic        write_i,
    input  logic [31:0] addr_i,
    output logic        ready_o,
    input  logic        wvalid_i,
    input  logic        wlast_i,
    input  logic [31:0] wdata_i,
    output logic        data_ok_o,
    output logic        data_last_o,
    output logic [31:0] rdata_o,
    output logic        err_o
);

    // 16 KB window, enough for four ppns per set
    localparam int MEM_WORDS = 4096;

    logic [31:0] mem [MEM_WORDS];
    int          seed;

    task automatic flag(input string why);
        $display("bus model: %s", why);
        err_o = 1'b1;
    endtask

    task automatic serve_burst();
        logic [31:0] base;
        logic        wr;
        int          gap;
        // random address phase delay
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) begin
            @(negedge clk);
            if (!valid_i) begin
                flag("bus_valid_o dropped before bus_ready_i");
            end
        end
        ready_o = 1'b1;
        base    = addr_i;
        wr      = write_i;
        if (base[3:0] != '0) begin
            flag("burst address is not line-aligned");
        end
        if (base[31:14] != '0) begin
            flag("burst address lies outside the modelled memory");
        end
        @(negedge clk);
        ready_o = 1'b0;
        for (int beat = 0; beat < 4; beat++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk);
            data_ok_o   = 1'b1;
            data_last_o = (beat == 3);
            if (wr) begin
                if (!wvalid_i) begin
                    flag("write beat accepted without bus_wvalid_o");
                end
                if (wlast_i != (beat == 3)) begin
                    flag("bus_wlast_o is not on the fourth write beat");
                end
                mem[{base[13:4], beat[1:0]}] = wdata_i;
            end else begin
                rdata_o = mem[{base[13:4], beat[1:0]}];
            end
            @(negedge clk);
            data_ok_o   = 1'b0;
            data_last_o = 1'b0;
        end
    endtask

    initial begin
        ready_o     = 1'b0;
        data_ok_o   = 1'b0;
        data_last_o = 1'b0;
        rdata_o     = '0;
        err_o       = 1'b0;
        // same seed and order as the testbench reference copy
        seed = 32'h4898;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $random(seed);
        end
        @(negedge clk);
        forever begin
            if (rst_n && valid_i) begin
                serve_burst();
            end else begin
                @(negedge clk);
            end
        end
    end

endmodule

// File: testbench/tb_lsu.sv
`timescale 1ns/1ns

module tb_lsu;

    localparam int CLK_PERIOD = 20;
    localparam int OP_BUDGET  = 140;
    localparam int MEM_WORDS  = 4096;

    logic           clk;
    logic           rst_n;
    logic           req;
    logic           we;
    logic [31:0]    addr;
    lsu_pkg::size_t size;
    logic           sign;
    logic [31:0]    wdata;
    logic           ack;
    logic [31:0]    rdata;

    logic        bus_valid, bus_write, bus_ready;
    logic [31:0] bus_addr;
    logic        bus_wvalid, bus_wlast;
    logic [31:0] bus_wdata;
    logic        bus_data_ok, bus_data_last;
    logic [31:0] bus_rdata;
    logic        bus_err;

    logic        seen_req;
    int          seed;
    int          op_cnt;
    logic [31:0] ref_mem [int];

    lsu_top dut_i (
        .clk (clk), .rst_n (rst_n),
        .req_i (req), .we_i (we), .addr_i (addr), .size_i (size),
        .sign_i (sign), .wdata_i (wdata), .ack_o (ack), .rdata_o (rdata),
        .bus_valid_o (bus_valid), .bus_write_o (bus_write),
        .bus_addr_o (bus_addr), .bus_ready_i (bus_ready),
        .bus_wvalid_o (bus_wvalid), .bus_wlast_o (bus_wlast),
        .bus_wdata_o (bus_wdata), .bus_data_ok_i (bus_data_ok),
        .bus_data_last_i (bus_data_last), .bus_rdata_i (bus_rdata)
    );

    bus_mem_model mem_i (
        .clk (clk), .rst_n (rst_n),
        .valid_i (bus_valid), .write_i (bus_write), .addr_i (bus_addr),
        .ready_o (bus_ready), .wvalid_i (bus_wvalid), .wlast_i (bus_wlast),
        .wdata_i (bus_wdata), .data_ok_o (bus_data_ok),
        .data_last_o (bus_data_last), .rdata_o (bus_rdata), .err_o (bus_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    initial begin
        #(OP_BUDGET * 200 * CLK_PERIOD);
        stop_run("watchdog expired before all operations completed");
    end

    always @(posedge clk) begin
        if (bus_err) begin
            stop_run("bus model saw a protocol violation");
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_req |-> !ack && !bus_valid && !bus_wvalid)
        else stop_run("ack_o or a bus valid was high before the first request");

    // ack changed at the previous edge, so req is checked there too
    a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else stop_run("ack_o rose while req_i was low");

    a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ack && req |=> ack)
        else stop_run("ack_o fell while req_i was still high");

    a_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        ack && !req |=> !ack)
        else stop_run("ack_o stayed high one cycle after req_i fell");

    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bus_valid && !bus_ready |=> bus_valid && $stable(bus_addr) && $stable(bus_write))
        else stop_run("bus address phase changed before bus_ready_i");

    a_line_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        bus_valid |-> bus_addr[3:0] == 4'h0)
        else stop_run("bus burst address is not line-aligned");

    a_wlast_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
        bus_wlast |-> bus_wvalid)
        else stop_run("bus_wlast_o high outside a write beat");

    // one four-phase transfer, entered and left on a falling edge
    task automatic access(input logic we_v, input logic [31:0] addr_v,
                          input lsu_pkg::size_t size_v, input logic sign_v,
                          input logic [31:0] wdata_v, output logic [31:0] rdata_v);
        we       = we_v;
        addr     = addr_v;
        size     = size_v;
        sign     = sign_v;
        wdata    = wdata_v;
        req      = 1'b1;
        seen_req = 1'b1;
        op_cnt++;
        do @(negedge clk); while (!ack);
        rdata_v = rdata;
        // some transfers keep req high past ack
        repeat (op_cnt % 3) @(negedge clk);
        req     = 1'b0;
        do @(negedge clk); while (ack);
    endtask

    task automatic store(input logic [31:0] addr_v, input lsu_pkg::size_t size_v,
                         input logic [31:0] data_v);
        logic [31:0] unused;
        logic [31:0] word;
        int          nbytes;
        int          off;
        access(1'b1, addr_v, size_v, 1'b0, data_v, unused);
        nbytes = (size_v == lsu_pkg::SIZE_WORD) ? 4 : (size_v == lsu_pkg::SIZE_HALF) ? 2 : 1;
        off    = int'(addr_v[1:0]);
        word   = ref_mem[int'(addr_v[13:2])];
        // low bytes of the data land at the byte offset
        for (int i = 0; i < nbytes; i++) begin
            word[8*(off+i) +: 8] = data_v[8*i +: 8];
        end
        ref_mem[int'(addr_v[13:2])] = word;
    endtask

    task automatic load(input logic [31:0] addr_v, input lsu_pkg::size_t size_v,
                        input logic sign_v);
        logic [31:0] got;
        logic [31:0] exp;
        logic [31:0] word;
        int          nbytes;
        int          off;
        nbytes = (size_v == lsu_pkg::SIZE_WORD) ? 4 : (size_v == lsu_pkg::SIZE_HALF) ? 2 : 1;
        off    = int'(addr_v[1:0]);
        word   = ref_mem[int'(addr_v[13:2])];
        exp    = '0;
        for (int i = 0; i < nbytes; i++) begin
            exp[8*i +: 8] = word[8*(off+i) +: 8];
        end
        if (sign_v && exp[8*nbytes-1]) begin
            for (int i = nbytes; i < 4; i++) begin
                exp[8*i +: 8] = 8'hFF;
            end
        end
        access(1'b0, addr_v, size_v, sign_v, 32'h0, got);
        assert (got === exp)
            else stop_run($sformatf("MISMATCH rdata_o addr=%h exp=%h got=%h", addr_v, exp, got));
    endtask

    // two sets, four ppns each, so random traffic keeps evicting
    task automatic random_op();
        logic [31:0]    r;
        logic [31:0]    a;
        logic [31:0]    d;
        lsu_pkg::size_t s;
        r = $random(seed);
        d = $random(seed);
        a = (r & 32'h0000_301C) | 32'h0000_0A40;
        case (r[21:20])
            2'd0: begin
                s       = lsu_pkg::SIZE_BYTE;
                a[1:0]  = r[23:22];
            end
            2'd1: begin
                s    = lsu_pkg::SIZE_HALF;
                a[1] = r[23];
            end
            default: s = lsu_pkg::SIZE_WORD;
        endcase
        if (r[24]) begin
            store(a, s, d);
        end else begin
            load(a, s, r[25]);
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        req      = 1'b0;
        we       = 1'b0;
        addr     = '0;
        size     = lsu_pkg::SIZE_WORD;
        sign     = 1'b0;
        wdata    = '0;
        seen_req = 1'b0;
        op_cnt   = 0;
        rst_n    = 1'b0;
        // mirrors the bus model's fill
        seed = 32'h4898;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = $random(seed);
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        store(32'h0000_0100, lsu_pkg::SIZE_WORD, 32'hCAFE_1234);
        load(32'h0000_0100, lsu_pkg::SIZE_WORD, 1'b0);
        load(32'h0000_0204, lsu_pkg::SIZE_WORD, 1'b0);

        // every byte has a different sign bit pattern
        store(32'h0000_0340, lsu_pkg::SIZE_WORD, 32'h80F1_7F01);
        for (int sg = 0; sg < 2; sg++) begin
            for (int off = 0; off < 4; off++) begin
                load(32'h0000_0340 + off, lsu_pkg::SIZE_BYTE, sg[0]);
                load(32'h0000_0344 + off, lsu_pkg::SIZE_BYTE, sg[0]);
            end
            for (int off = 0; off < 4; off += 2) begin
                load(32'h0000_0340 + off, lsu_pkg::SIZE_HALF, sg[0]);
                load(32'h0000_0344 + off, lsu_pkg::SIZE_HALF, sg[0]);
            end
        end

        // partial stores, then the whole word
        for (int off = 0; off < 4; off++) begin
            d = $random(seed);
            store(32'h0000_0380 + off, lsu_pkg::SIZE_BYTE, d);
            load(32'h0000_0380, lsu_pkg::SIZE_WORD, 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            d = $random(seed);
            store(32'h0000_0380 + off, lsu_pkg::SIZE_HALF, d);
            load(32'h0000_0380, lsu_pkg::SIZE_WORD, 1'b0);
        end

        // four ppns into set 0x20 of a two-way cache
        for (int p = 0; p < 4; p++) begin
            for (int w = 0; w < 4; w++) begin
                a = 32'(p << 12) | 32'h0000_0200 | 32'(w << 2);
                d = $random(seed);
                store(a, lsu_pkg::SIZE_WORD, d);
            end
        end
        for (int p = 0; p < 4; p++) begin
            for (int w = 0; w < 4; w++) begin
                a = 32'(p << 12) | 32'h0000_0200 | 32'(w << 2);
                load(a, lsu_pkg::SIZE_WORD, 1'b0);
            end
        end
        for (int p = 0; p < 4; p++) begin
            d = $random(seed);
            store(32'(p << 12) | 32'h0000_0204, lsu_pkg::SIZE_WORD, d);
        end
        for (int p = 0; p < 4; p++) begin
            load(32'(p << 12) | 32'h0000_0204, lsu_pkg::SIZE_WORD, 1'b0);
        end

        repeat (60) random_op();

        $display("TEST PASSED");
        $finish;
    end

endmodule
